//--- design/mem_pkg.sv
package mem_pkg;

    // --------------------------------------------------
    // Widths that carry a meaning
    // --------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [3:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;

    // Load kinds coming from the core
    typedef enum logic [2:0] {
        LOAD_B,
        LOAD_BU,
        LOAD_H,
        LOAD_HU,
        LOAD_W
    } load_op_e;

    // --------------------------------------------------
    // Core request and AXI read channels
    // --------------------------------------------------
    typedef struct packed {
        addr_t    addr;
        load_op_e op;
        logic     uncached;
    } mem_req_t;

    typedef struct packed {
        axi_id_t   id;
        addr_t     addr;
        axi_len_t  len;
        axi_size_t size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t    id;
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    // Ids that tell the two routes apart on the bus
    localparam axi_id_t UNCACHED_ID = 4'd0;
    localparam axi_id_t CACHED_ID   = 4'd1;

    // Beat size codes
    localparam axi_size_t SIZE_BYTE = 3'd0;
    localparam axi_size_t SIZE_HALF = 3'd1;
    localparam axi_size_t SIZE_WORD = 3'd2;

    localparam logic [1:0] BURST_INCR = 2'b01;

endpackage

//--- design/boot_sequencer.sv
module boot_sequencer #(
    parameter int RESET_HOLD   = 128,
    parameter int WARMUP_LOADS = 3
) (
    input  logic Clk,
    input  logic aresetn,
    input  logic load_done_i,
    output logic core_active_o,
    output logic cache_bypass_o
);

    localparam int HOLD_W = $clog2(RESET_HOLD + 1);
    localparam int WARM_W = $clog2(WARMUP_LOADS + 1);

    logic [HOLD_W-1:0] hold_cnt;
    logic [WARM_W-1:0] warm_cnt;

    // --------------------------------------------------
    // Core reset stretch
    // --------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            hold_cnt      <= '0;
            core_active_o <= 1'b0;
        end else begin
            if (hold_cnt != HOLD_W'(RESET_HOLD)) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
            // Output follows the counter end by one cycle
            if (hold_cnt == HOLD_W'(RESET_HOLD)) begin
                core_active_o <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Cache warm-up window
    // --------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            warm_cnt       <= '0;
            cache_bypass_o <= 1'b1;
        end else if (load_done_i && cache_bypass_o) begin
            warm_cnt <= warm_cnt + 1'b1;
            // Last warm-up load closes the window, never reopened
            if (warm_cnt == WARM_W'(WARMUP_LOADS - 1)) begin
                cache_bypass_o <= 1'b0;
            end
        end
    end

endmodule

//--- design/load_request_unit.sv
module load_request_unit
    import mem_pkg::*;
#(
    parameter int LINE_WORDS = 8
) (
    input  logic      Clk,
    input  logic      aresetn,
    input  logic      core_active_i,
    input  logic      cache_bypass_i,

    // Core side
    input  logic      req_valid_i,
    input  mem_req_t  req_i,
    output logic      addr_ok_o,
    output logic      data_ok_o,
    output word_t     rdata_o,

    // Towards the AXI read port
    output logic      start_o,
    output addr_t     start_addr_o,
    output axi_size_t start_size_o,
    output logic      start_cached_o,
    input  logic      ar_done_i,
    input  logic      beat_done_i,
    input  word_t     word_i
);

    // A one-word line gains nothing from a refill burst
    localparam bit LINE_REFILL = (LINE_WORDS > 1);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_ADDR,
        WAIT_DATA
    } lru_state_e;

    lru_state_e state;
    mem_req_t   req_q;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    word_t      load_val;

    // --------------------------------------------------
    // Request FSM
    // --------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            state     <= IDLE;
            addr_ok_o <= 1'b0;
            data_ok_o <= 1'b0;
        end else begin
            addr_ok_o <= 1'b0;
            data_ok_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (core_active_i && req_valid_i) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    state <= WAIT_ADDR;
                end
                WAIT_ADDR: begin
                    if (ar_done_i) begin
                        addr_ok_o <= 1'b1;
                        state     <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (beat_done_i) begin
                        data_ok_o <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request and load result registers
    always_ff @(posedge Clk) begin
        if (state == IDLE && core_active_i && req_valid_i) begin
            req_q <= req_i;
        end
        if (state == WAIT_DATA && beat_done_i) begin
            rdata_o <= load_val;
        end
    end

    // --------------------------------------------------
    // Start command
    // --------------------------------------------------
    assign start_o      = (state == ISSUE);
    assign start_addr_o = req_q.addr;

    // Route is settled late so a window closed by the previous load counts
    assign start_cached_o = LINE_REFILL && !req_q.uncached && !cache_bypass_i;

    always_comb begin
        case (req_q.op)
            LOAD_B, LOAD_BU: start_size_o = SIZE_BYTE;
            LOAD_H, LOAD_HU: start_size_o = SIZE_HALF;
            default:         start_size_o = SIZE_WORD;
        endcase
    end

    // --------------------------------------------------
    // Byte lane select and extension
    // --------------------------------------------------
    assign byte_sel = word_i[{req_q.addr[1:0], 3'b000} +: 8];
    assign half_sel = req_q.addr[1] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (req_q.op)
            LOAD_B:  load_val = {{24{byte_sel[7]}}, byte_sel};
            LOAD_BU: load_val = {24'b0, byte_sel};
            LOAD_H:  load_val = {{16{half_sel[15]}}, half_sel};
            LOAD_HU: load_val = {16'b0, half_sel};
            default: load_val = word_i;
        endcase
    end

endmodule

//--- design/axi_read_port.sv
module axi_read_port
    import mem_pkg::*;
#(
    parameter int LINE_WORDS = 8
) (
    input  logic      Clk,
    input  logic      aresetn,

    // Start command from the request unit
    input  logic      start_i,
    input  addr_t     start_addr_i,
    input  axi_size_t start_size_i,
    input  logic      start_cached_i,
    output logic      ar_done_o,
    output logic      beat_done_o,
    output word_t     word_o,

    // AXI read channels
    output axi_ar_t   axi_ar_o,
    output logic      axi_arvalid_o,
    input  logic      axi_arready_i,
    input  axi_r_t    axi_r_i,
    input  logic      axi_rvalid_i,
    output logic      axi_rready_o
);

    localparam addr_t LINE_MASK = addr_t'(LINE_WORDS * 4 - 1);

    axi_ar_t  ar_q;
    logic     arvalid_q;
    logic     busy_q;
    axi_len_t beat_cnt;
    axi_len_t want_idx;
    word_t    word_q;
    logic     beat_fire;
    logic     beat_hit;

    // --------------------------------------------------
    // Read-address channel
    // --------------------------------------------------
    always_ff @(posedge Clk) begin
        if (start_i) begin
            ar_q.burst <= BURST_INCR;
            if (start_cached_i) begin
                ar_q.id   <= CACHED_ID;
                ar_q.addr <= start_addr_i & ~LINE_MASK;
                ar_q.len  <= axi_len_t'(LINE_WORDS - 1);
                ar_q.size <= SIZE_WORD;
                want_idx  <= axi_len_t'((start_addr_i & LINE_MASK) >> 2);
            end else begin
                ar_q.id   <= UNCACHED_ID;
                ar_q.addr <= start_addr_i;
                ar_q.len  <= '0;
                ar_q.size <= start_size_i;
                want_idx  <= '0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            arvalid_q <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            if (start_i) begin
                arvalid_q <= 1'b1;
            end else if (ar_done_o) begin
                arvalid_q <= 1'b0;
            end
            // Burst outstanding from AR handshake up to the last beat
            if (ar_done_o) begin
                busy_q <= 1'b1;
            end else if (beat_done_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign ar_done_o     = arvalid_q && axi_arready_i;
    assign axi_ar_o      = ar_q;
    assign axi_arvalid_o = arvalid_q;

    // --------------------------------------------------
    // Read-data channel
    // --------------------------------------------------
    // Only beats carrying the id of this request are taken
    assign beat_fire = busy_q && axi_rvalid_i && (axi_r_i.id == ar_q.id);
    assign beat_hit  = (beat_cnt == want_idx);

    always_ff @(posedge Clk) begin
        if (ar_done_o) begin
            beat_cnt <= '0;
        end else if (beat_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_hit) begin
                word_q <= axi_r_i.data;
            end
        end
    end

    assign axi_rready_o = busy_q;
    assign beat_done_o  = beat_fire && axi_r_i.last;

    // Wanted beat may be the last one itself
    assign word_o = beat_hit ? axi_r_i.data : word_q;

endmodule

//--- design/mem_port_top.sv
module mem_port_top
    import mem_pkg::*;
#(
    parameter int RESET_HOLD   = 128,
    parameter int WARMUP_LOADS = 3,
    parameter int LINE_WORDS   = 8
) (
    input  logic     Clk,
    input  logic     aresetn,

    // Core side
    input  logic     core_req_valid_i,
    input  mem_req_t core_req_i,
    output logic     core_addr_ok_o,
    output logic     core_data_ok_o,
    output word_t    core_rdata_o,
    output logic     core_resetn_o,

    // AXI read side
    output axi_ar_t  axi_ar_o,
    output logic     axi_arvalid_o,
    input  logic     axi_arready_i,
    input  axi_r_t   axi_r_i,
    input  logic     axi_rvalid_i,
    output logic     axi_rready_o
);

    logic      cache_bypass;
    logic      start;
    addr_t     start_addr;
    axi_size_t start_size;
    logic      start_cached;
    logic      ar_done;
    logic      beat_done;
    word_t     beat_word;

    // --------------------------------------------------
    // Input side
    // --------------------------------------------------
    boot_sequencer #(
        .RESET_HOLD   (RESET_HOLD),
        .WARMUP_LOADS (WARMUP_LOADS)
    ) boot_sequencer_i (
        .Clk            (Clk),
        .aresetn        (aresetn),
        .load_done_i    (core_data_ok_o),
        .core_active_o  (core_resetn_o),
        .cache_bypass_o (cache_bypass)
    );

    // --------------------------------------------------
    // Request handling
    // --------------------------------------------------
    load_request_unit #(
        .LINE_WORDS (LINE_WORDS)
    ) load_request_unit_i (
        .Clk            (Clk),
        .aresetn        (aresetn),
        .core_active_i  (core_resetn_o),
        .cache_bypass_i (cache_bypass),
        .req_valid_i    (core_req_valid_i),
        .req_i          (core_req_i),
        .addr_ok_o      (core_addr_ok_o),
        .data_ok_o      (core_data_ok_o),
        .rdata_o        (core_rdata_o),
        .start_o        (start),
        .start_addr_o   (start_addr),
        .start_size_o   (start_size),
        .start_cached_o (start_cached),
        .ar_done_i      (ar_done),
        .beat_done_i    (beat_done),
        .word_i         (beat_word)
    );

    // --------------------------------------------------
    // Output side
    // --------------------------------------------------
    axi_read_port #(
        .LINE_WORDS (LINE_WORDS)
    ) axi_read_port_i (
        .Clk            (Clk),
        .aresetn        (aresetn),
        .start_i        (start),
        .start_addr_i   (start_addr),
        .start_size_i   (start_size),
        .start_cached_i (start_cached),
        .ar_done_o      (ar_done),
        .beat_done_o    (beat_done),
        .word_o         (beat_word),
        .axi_ar_o       (axi_ar_o),
        .axi_arvalid_o  (axi_arvalid_o),
        .axi_arready_i  (axi_arready_i),
        .axi_r_i        (axi_r_i),
        .axi_rvalid_i   (axi_rvalid_i),
        .axi_rready_o   (axi_rready_o)
    );

endmodule

//--- verification/axi_slave_model.sv
module axi_slave_model
    import mem_pkg::*;
(
    input  logic       Clk,
    input  logic       aresetn,
    input  logic [3:0] stall_i,
    input  axi_ar_t    ar_i,
    input  logic       arvalid_i,
    output logic       arready_o,
    output axi_r_t     r_o,
    output logic       rvalid_o,
    input  logic       rready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic     busy;
    axi_ar_t  ar_q;
    axi_len_t beat;

    // Memory contents: word address xor a fixed pattern
    function automatic word_t word_at(input addr_t byte_addr);
        return {2'b00, byte_addr[31:2]} ^ 32'h5A5A_0000;
    endfunction

    always @(posedge Clk) begin
        if (!aresetn) begin
            busy      <= 1'b0;
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            r_o       <= '0;
            ar_q      <= '0;
            beat      <= '0;
        end else if (!busy) begin
            if (arvalid_i && arready_o) begin
                busy      <= 1'b1;
                ar_q      <= ar_i;
                beat      <= '0;
                arready_o <= 1'b0;
            end else begin
                // Ready about three cycles in four
                arready_o <= (stall_i[1:0] != 2'b00);
            end
        end else if (rvalid_o) begin
            if (rready_i) begin
                rvalid_o <= 1'b0;
                beat     <= beat + 1'b1;
                if (r_o.last) begin
                    busy <= 1'b0;
                end
            end
        end else if (stall_i[3:2] != 2'b00) begin
            rvalid_o   <= 1'b1;
            r_o.id     <= ar_q.id;
            r_o.data   <= word_at(ar_q.addr + (addr_t'(beat) << 2));
            r_o.resp   <= 2'b00;
            r_o.last   <= (beat == ar_q.len);
        end
    end

endmodule

//--- verification/mem_port_tb.sv
module mem_port_tb
    import mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_HOLD   = 128;
    localparam int WARMUP_LOADS = 3;
    localparam int LINE_WORDS   = 8;
    localparam int NUM_TESTS    = 12;
    localparam int CYCLE_LIMIT  = RESET_HOLD + NUM_TESTS * 60;

    typedef struct packed {
        mem_req_t req;
        logic     cached;
    } test_vec_t;

    logic       Clk;
    logic       aresetn;
    logic       core_req_valid_i;
    mem_req_t   core_req_i;
    logic       core_addr_ok_o;
    logic       core_data_ok_o;
    word_t      core_rdata_o;
    logic       core_resetn_o;
    axi_ar_t    axi_ar_o;
    logic       axi_arvalid_o;
    logic       axi_arready_i;
    axi_r_t     axi_r_i;
    logic       axi_rvalid_i;
    logic       axi_rready_o;
    logic [3:0] stall_rand;

    test_vec_t tests [NUM_TESTS];
    int        errors = 0;
    int        mon_errors = 0;
    int        cycles = 0;
    int        addr_ok_total = 0;
    int        ar_total = 0;
    int        outstanding = 0;
    logic      ar_waiting = 1'b0;
    axi_ar_t   ar_held;
    axi_ar_t   ar_issued;

    mem_port_top #(
        .RESET_HOLD   (RESET_HOLD),
        .WARMUP_LOADS (WARMUP_LOADS),
        .LINE_WORDS   (LINE_WORDS)
    ) mem_port_top_i (.*);

    axi_slave_model axi_slave_model_i (
        .Clk       (Clk),
        .aresetn   (aresetn),
        .stall_i   (stall_rand),
        .ar_i      (axi_ar_o),
        .arvalid_i (axi_arvalid_o),
        .arready_o (axi_arready_i),
        .r_o       (axi_r_i),
        .rvalid_o  (axi_rvalid_i),
        .rready_i  (axi_rready_o)
    );

    // --------------------------------------------------
    // Expected values
    // --------------------------------------------------
    function automatic word_t expected_load(input mem_req_t q);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = {2'b00, q.addr[31:2]} ^ 32'h5A5A_0000;
        b = 8'(w >> {q.addr[1:0], 3'b000});
        h = 16'(w >> {q.addr[1], 4'b0000});
        case (q.op)
            LOAD_B:  return {{24{b[7]}}, b};
            LOAD_BU: return {24'h0, b};
            LOAD_H:  return {{16{h[15]}}, h};
            LOAD_HU: return {16'h0, h};
            default: return w;
        endcase
    endfunction

    function automatic axi_ar_t expected_ar(input test_vec_t t);
        axi_ar_t a;
        a.burst = BURST_INCR;
        a.id    = t.cached ? CACHED_ID : UNCACHED_ID;
        if (t.cached) begin
            a.addr = t.req.addr & ~addr_t'(LINE_WORDS * 4 - 1);
            a.len  = axi_len_t'(LINE_WORDS - 1);
            a.size = SIZE_WORD;
        end else begin
            a.addr = t.req.addr;
            a.len  = '0;
            case (t.req.op)
                LOAD_B, LOAD_BU: a.size = SIZE_BYTE;
                LOAD_H, LOAD_HU: a.size = SIZE_HALF;
                default:         a.size = SIZE_WORD;
            endcase
        end
        return a;
    endfunction

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // Slave stall pattern
    initial begin
        stall_rand = 4'($urandom(55));
        forever begin
            @(posedge Clk);
            stall_rand <= 4'($urandom);
        end
    end

    always @(posedge Clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no result after %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Bus monitor, sampled between edges
    // --------------------------------------------------
    always @(negedge Clk) begin
        if (aresetn) begin
            if (axi_arvalid_o && !core_resetn_o) begin
                $display("Read address issued at %0t while the core is held in reset", $time);
                mon_errors++;
            end
            if (ar_waiting && (!axi_arvalid_o || axi_ar_o != ar_held)) begin
                $display("Mismatch at %0t: AR valid or fields changed while stalled", $time);
                mon_errors++;
            end
            if (axi_rvalid_i && !axi_rready_o) begin
                $display("Read data offered at %0t with rready low during a burst", $time);
                mon_errors++;
            end
            ar_waiting = axi_arvalid_o && !axi_arready_i;
            ar_held    = axi_ar_o;
            if (axi_arvalid_o && axi_arready_i) begin
                ar_issued = axi_ar_o;
                ar_total++;
            end
            if (core_addr_ok_o) begin
                if (outstanding != 0) begin
                    $display("Second addr_ok at %0t before the data_ok", $time);
                    mon_errors++;
                end
                outstanding = 1;
                addr_ok_total++;
            end
            if (core_data_ok_o) begin
                if (outstanding == 0) begin
                    $display("data_ok at %0t without a preceding addr_ok", $time);
                    mon_errors++;
                end
                outstanding = 0;
            end
        end
    end

    // --------------------------------------------------
    // Stimulus and checks
    // --------------------------------------------------
    initial begin
        int       low_cycles;
        int       fails_before;
        int       ok_base;
        int       ar_base;
        axi_ar_t  exp_ar;
        word_t    exp_data;
        load_op_e op;

        aresetn          = 1'b0;
        core_req_valid_i = 1'b0;
        core_req_i       = '0;
        // First three are inside the warm-up window
        tests[0]  = '{'{32'h0000_0200, LOAD_W,  1'b0}, 1'b0};
        tests[1]  = '{'{32'h0004_0202, LOAD_BU, 1'b0}, 1'b0};
        tests[2]  = '{'{32'h0002_0206, LOAD_H,  1'b1}, 1'b0};
        tests[3]  = '{'{32'h0000_0344, LOAD_W,  1'b0}, 1'b1};
        tests[4]  = '{'{32'h0000_035C, LOAD_W,  1'b0}, 1'b1};
        tests[5]  = '{'{32'h0002_0204, LOAD_H,  1'b0}, 1'b1};
        tests[6]  = '{'{32'h0002_0201, LOAD_B,  1'b1}, 1'b0};
        tests[7]  = '{'{32'h0006_0207, LOAD_B,  1'b1}, 1'b0};
        tests[8]  = '{'{32'h0002_0204, LOAD_BU, 1'b0}, 1'b1};
        tests[9]  = '{'{32'h0002_0205, LOAD_B,  1'b0}, 1'b1};
        tests[10] = '{'{32'h0002_0200, LOAD_HU, 1'b0}, 1'b1};
        tests[11] = '{'{32'h0002_021A, LOAD_HU, 1'b1}, 1'b0};

        repeat (2) @(posedge Clk);
        aresetn          <= 1'b1;
        // Request already pending during the reset stretch
        core_req_valid_i <= 1'b1;
        core_req_i       <= tests[0].req;
        @(posedge Clk);
        @(negedge Clk);
        if (core_addr_ok_o || core_data_ok_o || axi_arvalid_o || axi_rready_o) begin
            $display("Outputs not idle after reset at %0t", $time);
            errors++;
        end
        low_cycles = 0;
        while (!core_resetn_o && low_cycles <= RESET_HOLD) begin
            low_cycles++;
            @(negedge Clk);
        end
        if (low_cycles != RESET_HOLD) begin
            $display("Mismatch at %0t: core reset low %0d cycles, expected %0d",
                     $time, low_cycles, RESET_HOLD);
            errors++;
        end
        $display("reset hold: %0d cycles, %s", low_cycles,
                 (errors + mon_errors == 0) ? "pass" : "fail");

        @(posedge Clk);
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (i > 0) begin
                core_req_valid_i <= 1'b1;
                core_req_i       <= tests[i].req;
            end
            fails_before = errors + mon_errors;
            ok_base      = addr_ok_total;
            ar_base      = ar_total;
            exp_ar       = expected_ar(tests[i]);
            exp_data     = expected_load(tests[i].req);
            @(negedge Clk);
            while (!core_addr_ok_o) @(negedge Clk);
            @(posedge Clk);
            core_req_valid_i <= 1'b0;
            @(negedge Clk);
            while (!core_data_ok_o) @(negedge Clk);

            if (ar_total - ar_base != 1 || addr_ok_total - ok_base != 1) begin
                $display("Load %0d did not give exactly one AR handshake and one addr_ok", i);
                errors++;
            end
            if (ar_issued != exp_ar) begin
                $display("Mismatch at %0t: AR id %0d addr %h len %0d size %0d",
                         $time, ar_issued.id, ar_issued.addr, ar_issued.len, ar_issued.size);
                $display("    expected id %0d addr %h len %0d size %0d",
                         exp_ar.id, exp_ar.addr, exp_ar.len, exp_ar.size);
                errors++;
            end
            if (core_rdata_o !== exp_data) begin
                $display("Mismatch at %0t: rdata %h, expected %h", $time, core_rdata_o, exp_data);
                errors++;
            end
            @(posedge Clk);
            op = tests[i].req.op;
            $display("load %0d %s at %h: %s", i, op.name(), tests[i].req.addr,
                     (errors + mon_errors == fails_before) ? "pass" : "fail");
        end

        $display("Checks done: %0d loads, %0d errors", NUM_TESTS, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- mem_port_top.f
design/mem_pkg.sv
design/boot_sequencer.sv
design/load_request_unit.sv
design/axi_read_port.sv
design/mem_port_top.sv
verification/axi_slave_model.sv
verification/mem_port_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module mem_port_tb -f mem_port_top.f -o Vmem_port_tb > build.log 2>&1 \
    && ./obj_dir/Vmem_port_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation result: FAIL"; exit 1; }
echo "Simulation result: PASS"
exit 0
